// File: Makefile
# Verilator build and run of the MSX memory testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --assert --top-module tb_msx_memory_top -f compile.f -o sim
	./obj_dir/sim | tee sim.log
	@if grep -qx "Finished with errors" sim.log; then \
		echo "TEST FAILED"; exit 1; \
	fi
	@if ! grep -qx "Finished with no errors" sim.log; then \
		echo "TEST FAILED, run ended early"; exit 1; \
	fi
	@echo "TEST PASSED"

clean:
	rm -rf obj_dir sim.log

// File: compile.f
msx_pkg.sv
msx_layout_table.sv
msx2_ram_mapper.sv
msx_slots.sv
msx_memory_top.sv
msx_slots_sva.sv
tb_msx_memory_top.sv

// File: msx2_ram_mapper.sv
`timescale 1ns/1ps
`default_nettype none

module msx2_ram_mapper #(
   parameter int bank_bits = 8
) (
   input  wire         clk,
   input  wire         reset,
   input  wire  [15:0] cpu_addr,
   input  wire   [7:0] cpu_dout,
   input  wire         cpu_wr,
   input  wire         cpu_rd,
   input  wire         cpu_iorq,
   input  wire         cpu_m1,
   // region length in 16 kb blocks, power of two
   input  wire   [7:0] ram_block_count,
   output logic [21:0] mapper_addr,
   output logic  [7:0] mapper_dout,
   output logic        mapper_req
);

   // bank bits the hardware keeps
   localparam logic [7:0] bank_lim = 8'((9'd1 << bank_bits) - 9'd1);

   // one bank register per page, port fc is page 0
   logic [bank_bits-1:0] bank_reg [4];

   // io decode on the low address byte, m1 excludes int acknowledge
   wire io_sel = cpu_iorq & ~cpu_m1 & (cpu_addr[7:2] == 6'b111111);

   // valid bank bits for this region
   // count of zero wraps to all ones, i.e. 256 blocks
   wire [7:0] bank_mask = (ram_block_count - 8'd1) & bank_lim;

   // write side
   // power up like a 64 kb machine, pages map to banks 3 2 1 0
   always_ff @(posedge clk, posedge reset) begin
      if (reset) begin
         bank_reg[0] <= bank_bits'(3);
         bank_reg[1] <= bank_bits'(2);
         bank_reg[2] <= bank_bits'(1);
         bank_reg[3] <= bank_bits'(0);
      end else begin
         if (io_sel & cpu_wr) begin
            bank_reg[cpu_addr[1:0]] <= cpu_dout[bank_bits-1:0];
         end
      end
   end

   // bank of the page being accessed
   wire [7:0] page_bank = 8'(bank_reg[cpu_addr[15:14]]) & bank_mask;

   // offset inside the region
   assign mapper_addr = {page_bank, cpu_addr[13:0]};

   // readback port selected by low address bits
   wire [7:0] port_bank = 8'(bank_reg[cpu_addr[1:0]]);

   // bits beyond the mask read as one
   assign mapper_dout = port_bank | ~bank_mask;
   assign mapper_req  = io_sel & cpu_rd;

endmodule

`default_nettype wire

// File: msx_layout_table.sv
`timescale 1ns/1ps
`default_nettype none

module msx_layout_table (
   input  wire                       clk,
   input  wire                       reset,
   // configuration port
   input  wire                       cfg_wr,
   input  wire                 [1:0] cfg_sel,
   input  wire                 [5:0] cfg_index,
   input  wire msx_pkg::cfg_word_t   cfg_data,
   // tables towards the slot decoder
   output msx_pkg::block_t           slot_layout [msx_pkg::LAYOUT_N],
   output msx_pkg::lookup_ram_t      lookup_ram [msx_pkg::REGION_N],
   output logic                [3:0] expander_en
);

   // write strobes per target
   wire layout_wr   = cfg_wr & (cfg_sel == msx_pkg::CFG_SEL_LAYOUT);
   wire region_wr   = cfg_wr & (cfg_sel == msx_pkg::CFG_SEL_REGION);
   wire expander_wr = cfg_wr & (cfg_sel == msx_pkg::CFG_SEL_EXPANDER);

   // only 16 regions, upper index bits must be clear
   wire region_hit = (cfg_index[5:4] == 2'b00);

   // layout entry as seen through the union
   msx_pkg::block_t new_block;
   assign new_block = cfg_data.layout.blk;

   // layout table
   // every page starts unused, so nothing reaches ram before setup
   always_ff @(posedge clk, posedge reset) begin
      if (reset) begin
         for (int i = 0; i < msx_pkg::LAYOUT_N; i++) begin
            slot_layout[i].mapper     <= msx_pkg::MAPPER_UNUSED;
            slot_layout[i].ref_ram    <= 4'd0;
            slot_layout[i].offset_ram <= 2'd0;
         end
      end else begin
         if (layout_wr) begin
            slot_layout[cfg_index] <= new_block;
         end
      end
   end

   // region table
   always_ff @(posedge clk, posedge reset) begin
      if (reset) begin
         for (int i = 0; i < msx_pkg::REGION_N; i++) begin
            lookup_ram[i] <= '0;
         end
      end else begin
         // out of range index silently dropped
         if (region_wr & region_hit) begin
            lookup_ram[cfg_index[3:0]] <= cfg_data.region;
         end
      end
   end

   // expander enables
   // bit n set means primary slot n has subslots
   always_ff @(posedge clk, posedge reset) begin
      if (reset) begin
         expander_en <= 4'b0000;
      end else begin
         if (expander_wr) begin
            expander_en <= cfg_data[3:0];
         end
      end
   end

endmodule

`default_nettype wire

// File: msx_memory_top.sv
`timescale 1ns/1ps
`default_nettype none

module msx_memory_top #(
   parameter int bank_bits = 8
) (
   input  wire                             clk,
   input  wire                             reset,
   // configuration port
   input  wire                             cfg_wr,
   input  wire                       [1:0] cfg_sel,
   input  wire                       [5:0] cfg_index,
   input  wire msx_pkg::cfg_word_t         cfg_data,
   // cpu bus
   input  wire                      [15:0] cpu_addr,
   input  wire                       [7:0] cpu_dout,
   output wire                       [7:0] cpu_din,
   input  wire                             cpu_wr,
   input  wire                             cpu_rd,
   input  wire                             cpu_mreq,
   input  wire                             cpu_iorq,
   input  wire                             cpu_m1,
   input  wire                       [1:0] active_slot,
   // external ram
   output wire [msx_pkg::RAM_ADDR_W-1:0]   ram_addr,
   output wire                       [7:0] ram_din,
   input  wire                       [7:0] ram_dout,
   output wire                             ram_rnw,
   output wire                             ram_ce
);

   // tables from config registers to decoder
   msx_pkg::block_t      slot_layout [msx_pkg::LAYOUT_N];
   msx_pkg::lookup_ram_t lookup_ram [msx_pkg::REGION_N];
   logic           [3:0] expander_en;

   msx_layout_table msx_layout_table_inst (
      .clk(clk),
      .reset(reset),
      .cfg_wr(cfg_wr),
      .cfg_sel(cfg_sel),
      .cfg_index(cfg_index),
      .cfg_data(cfg_data),
      .slot_layout(slot_layout),
      .lookup_ram(lookup_ram),
      .expander_en(expander_en)
   );

   // slot decoder, carries the msx2 mapper inside
   msx_slots #(
      .bank_bits(bank_bits)
   ) msx_slots_inst (
      .clk(clk),
      .reset(reset),
      .cpu_addr(cpu_addr),
      .cpu_dout(cpu_dout),
      .cpu_din(cpu_din),
      .cpu_wr(cpu_wr),
      .cpu_rd(cpu_rd),
      .cpu_mreq(cpu_mreq),
      .cpu_iorq(cpu_iorq),
      .cpu_m1(cpu_m1),
      .active_slot(active_slot),
      .slot_layout(slot_layout),
      .lookup_ram(lookup_ram),
      .expander_en(expander_en),
      .ram_addr(ram_addr),
      .ram_din(ram_din),
      .ram_dout(ram_dout),
      .ram_rnw(ram_rnw),
      .ram_ce(ram_ce)
   );

endmodule

`default_nettype wire

// File: msx_pkg.sv
`default_nettype none

package msx_pkg;

   // external ram byte address width
   localparam int RAM_ADDR_W = 27;

   // cpu address bits inside one 16 kb page
   localparam int PAGE_W = 14;

   // table depths
   // 4 slots x 4 subslots x 4 pages
   localparam int LAYOUT_N = 64;
   localparam int REGION_N = 16;

   // configuration port targets
   localparam logic [1:0] CFG_SEL_LAYOUT   = 2'd0;
   localparam logic [1:0] CFG_SEL_REGION   = 2'd1;
   localparam logic [1:0] CFG_SEL_EXPANDER = 2'd2;

   // how a page turns the cpu address into a ram offset
   typedef enum logic [2:0] {
      MAPPER_NONE,
      MAPPER_RAM,
      MAPPER_LINEAR,
      MAPPER_OFFSET,
      MAPPER_UNUSED
   } mapper_typ_t;

   // layout entry, one per slot / subslot / page
   typedef struct packed {
      mapper_typ_t mapper;
      // region table index
      logic  [3:0] ref_ram;
      // extra 16 kb pages, used by mapper none
      logic  [1:0] offset_ram;
   } block_t;

   // ram region entry
   typedef struct packed {
      // base byte address in external ram
      logic [RAM_ADDR_W-1:0] addr;
      // region length in 16 kb blocks
      logic            [7:0] size;
      // write protect
      logic                  ro;
   } lookup_ram_t;

   // one configuration word, two readings
   // layout view keeps the entry in the low bits, rest is zero
   // region view spans the whole word
   // the expander mask is simply the low nibble of the raw word
   typedef union packed {
      struct packed {
         logic [$bits(lookup_ram_t)-$bits(block_t)-1:0] pad;
         block_t                                        blk;
      } layout;
      lookup_ram_t region;
   } cfg_word_t;

endpackage

`default_nettype wire

// File: msx_slots.sv
`timescale 1ns/1ps
`default_nettype none

module msx_slots #(
   parameter int bank_bits = 8
) (
   input  wire                             clk,
   input  wire                             reset,
   // cpu bus
   input  wire                      [15:0] cpu_addr,
   input  wire                       [7:0] cpu_dout,
   output logic                      [7:0] cpu_din,
   input  wire                             cpu_wr,
   input  wire                             cpu_rd,
   input  wire                             cpu_mreq,
   input  wire                             cpu_iorq,
   input  wire                             cpu_m1,
   input  wire                       [1:0] active_slot,
   // tables from the configuration register file
   input  wire msx_pkg::block_t            slot_layout [msx_pkg::LAYOUT_N],
   input  wire msx_pkg::lookup_ram_t       lookup_ram [msx_pkg::REGION_N],
   input  wire                       [3:0] expander_en,
   // external ram, asynchronous read
   output logic [msx_pkg::RAM_ADDR_W-1:0] ram_addr,
   output logic                      [7:0] ram_din,
   input  wire                       [7:0] ram_dout,
   output logic                            ram_rnw,
   output logic                            ram_ce
);

   localparam int aw = msx_pkg::RAM_ADDR_W;

   // secondary slot registers, two bits per page
   logic [7:0] subslot_reg [4];

   // current slot has subslots
   wire slot_expanded = expander_en[active_slot];

   // ffff on an expanded slot is the expander register
   wire exp_sel = cpu_mreq & (cpu_addr == 16'hFFFF) & slot_expanded;

   always_ff @(posedge clk, posedge reset) begin
      if (reset) begin
         for (int i = 0; i < 4; i++) begin
            subslot_reg[i] <= 8'h00;
         end
      end else begin
         if (exp_sel & cpu_wr) begin
            subslot_reg[active_slot] <= cpu_dout;
         end
      end
   end

   // layout lookup
   wire [1:0] page    = cpu_addr[15:14];
   wire [7:0] cur_reg = subslot_reg[active_slot];

   // plain slots always decode as subslot 0
   wire [1:0] subslot = slot_expanded ? cur_reg[{page, 1'b0} +: 2] : 2'b00;

   wire [5:0] layout_id = {active_slot, subslot, page};

   msx_pkg::block_t      entry;
   msx_pkg::lookup_ram_t region;

   assign entry  = slot_layout[layout_id];
   assign region = lookup_ram[entry.ref_ram];

   // msx2 memory mapper, sized by the selected region
   wire [21:0] mapper_addr;
   wire  [7:0] mapper_dout;
   wire        mapper_req;

   msx2_ram_mapper #(
      .bank_bits(bank_bits)
   ) msx2_ram_mapper_inst (
      .clk(clk),
      .reset(reset),
      .cpu_addr(cpu_addr),
      .cpu_dout(cpu_dout),
      .cpu_wr(cpu_wr),
      .cpu_rd(cpu_rd),
      .cpu_iorq(cpu_iorq),
      .cpu_m1(cpu_m1),
      .ram_block_count(region.size),
      .mapper_addr(mapper_addr),
      .mapper_dout(mapper_dout),
      .mapper_req(mapper_req)
   );

   // candidate offsets
   // none: fixed page plus offset_ram pages
   wire [aw-1:0] none_addr = aw'(cpu_addr[13:0]) +
                             (aw'(entry.offset_ram) << msx_pkg::PAGE_W);

   // linear: whole cpu address, wrapped at region size
   wire [aw-1:0] linear_addr = aw'(cpu_addr) &
                               ((aw'(region.size) << msx_pkg::PAGE_W) - aw'(1));

   // offset: image starts at 4000h
   wire [aw-1:0] offset_addr = aw'(cpu_addr) - aw'(16'h4000);

   logic [aw-1:0] map_offset;

   always_comb begin
      case (entry.mapper)
         msx_pkg::MAPPER_NONE:   map_offset = none_addr;
         msx_pkg::MAPPER_RAM:    map_offset = aw'(mapper_addr);
         msx_pkg::MAPPER_LINEAR: map_offset = linear_addr;
         msx_pkg::MAPPER_OFFSET: map_offset = offset_addr;
         default:                map_offset = '0;
      endcase
   end

   wire page_used = (entry.mapper != msx_pkg::MAPPER_UNUSED);

   // ram side
   assign ram_addr = region.addr + map_offset;
   assign ram_din  = cpu_dout;
   assign ram_rnw  = cpu_rd;
   // write protect only blocks writes, reads still go out
   assign ram_ce   = cpu_mreq & (cpu_rd | (cpu_wr & ~region.ro)) & page_used;

   // data back to the cpu
   // io readback first, it shares no cycle with a memory access
   always_comb begin
      if (mapper_req) begin
         cpu_din = mapper_dout;
      end else if (exp_sel & cpu_rd) begin
         // expander reads back inverted
         cpu_din = ~cur_reg;
      end else if (!page_used) begin
         // open bus
         cpu_din = 8'hFF;
      end else begin
         cpu_din = ram_dout;
      end
   end

endmodule

`default_nettype wire

// File: msx_slots_sva.sv
`timescale 1ns/1ps
`default_nettype none

module msx_slots_sva (
   input wire        clk,
   input wire        reset,
   input wire [15:0] cpu_addr,
   input wire  [7:0] cpu_dout,
   input wire  [7:0] cpu_din,
   input wire        cpu_wr,
   input wire        cpu_rd,
   input wire        cpu_mreq,
   input wire  [1:0] active_slot,
   input wire        exp_sel,
   input wire        region_ro,
   input wire        ram_ce
);

   // ram only selected inside a memory cycle
   ce_needs_mreq: assert property (@(posedge clk) disable iff (reset)
      ram_ce |-> cpu_mreq)
      else $error("ram_ce high outside a memory request");

   // write protect
   ro_blocks_write: assert property (@(posedge clk) disable iff (reset)
      (cpu_wr && !cpu_rd && region_ro) |-> !ram_ce)
      else $error("ram_ce high for a write to a read-only region");

   // expander write then read in the next cycle, same slot
   expander_readback: assert property (@(posedge clk) disable iff (reset)
      ($past(exp_sel && cpu_wr) && exp_sel && cpu_rd &&
       (active_slot == $past(active_slot)) && (cpu_addr == 16'hFFFF))
      |-> (cpu_din == ~$past(cpu_dout)))
      else $error("expander register did not read back inverted");

endmodule

bind msx_slots msx_slots_sva msx_slots_sva_inst (
   .clk(clk),
   .reset(reset),
   .cpu_addr(cpu_addr),
   .cpu_dout(cpu_dout),
   .cpu_din(cpu_din),
   .cpu_wr(cpu_wr),
   .cpu_rd(cpu_rd),
   .cpu_mreq(cpu_mreq),
   .active_slot(active_slot),
   .exp_sel(exp_sel),
   .region_ro(region.ro),
   .ram_ce(ram_ce)
);

`default_nettype wire

// File: msx_trace.txt
# op name slot addr data exp_din exp_ram_addr exp_ce (hex), op c=config r/w=memory i/o=port
# config lines: slot column is cfg_sel, addr column is cfg_index, data is the 36-bit word
r rst_rd      0 0000 00        ff 0000000 0
r rst_ffff    1 ffff 00        ff 0000000 0
i rst_fc      0 00fc 00        03 0000000 0
i rst_fd      0 00fd 00        02 0000000 0
i rst_fe      0 00fe 00        01 0000000 0
i rst_ff      0 00ff 00        00 0000000 0
c region0     1 0000 000000008 00 0000000 0
c region1     1 0001 004000004 00 0000000 0
c region2     1 0002 008000005 00 0000000 0
c region3     1 0003 00c000004 00 0000000 0
c expander    2 0000 000000002 00 0000000 0
c lay_s0p0    0 0000 000000040 00 0000000 0
c lay_s0p3    0 0003 000000040 00 0000000 0
c lay_s1s0p1  0 0011 000000005 00 0000000 0
c lay_s1s0p2  0 0012 000000084 00 0000000 0
c lay_s1s1p1  0 0015 0000000cc 00 0000000 0
c lay_s1s1p2  0 0016 000000008 00 0000000 0
i map_mask    0 00ff 00        fc 0000000 0
w map_wr      0 0123 5a        00 000c123 1
o map_bank    0 00fc 06        00 0000000 0
w map_wr_b2   0 0123 a5        00 0008123 1
i map_rdback  0 00fc 00        fe 0000000 0
r map_rd_b2   0 0123 00        a5 0008123 1
w plain_ffff  0 ffff 77        00 0003fff 1
r plain_rd    0 ffff 00        77 0003fff 1
w none_wr     1 4123 11        00 0024123 1
r none_rd     1 4123 00        11 0024123 1
w linear_wr   1 8456 22        00 0020456 1
r linear_rd   1 8456 00        22 0020456 1
w exp_wr      1 ffff 14        00 0000000 0
r exp_rd      1 ffff 00        eb 0000000 0
w offset_wr   1 4010 33        00 0060010 1
r offset_rd   1 4010 00        33 0060010 1
w ro_wr       1 8020 44        00 0000000 0
r ro_rd       1 8020 00        24 0040020 1

// File: tb_msx_memory_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_msx_memory_top;

   // most trace lines read before giving up
   localparam int max_lines = 100;

   logic                clk;
   logic                reset;
   logic                cfg_wr;
   logic          [1:0] cfg_sel;
   logic          [5:0] cfg_index;
   msx_pkg::cfg_word_t  cfg_data;
   logic         [15:0] cpu_addr;
   logic          [7:0] cpu_dout;
   wire           [7:0] cpu_din;
   logic                cpu_wr;
   logic                cpu_rd;
   logic                cpu_mreq;
   logic                cpu_iorq;
   logic                cpu_m1;
   logic          [1:0] active_slot;
   wire          [26:0] ram_addr;
   wire           [7:0] ram_din;
   wire           [7:0] ram_dout;
   wire                 ram_rnw;
   wire                 ram_ce;

   // 1 mb external ram
   logic [7:0] ram_mem [0:1048575];

   int error_count;
   int check_count;
   int line_count;
   int fd;
   int field_count;

   // one trace line
   logic [8*128-1:0] line_buf;
   logic   [8*16-1:0] t_name;
   logic        [7:0] t_op;
   logic        [7:0] t_slot;
   logic       [15:0] t_addr;
   logic       [35:0] t_data;
   logic        [7:0] t_din;
   logic       [26:0] t_ram_addr;
   logic        [7:0] t_ce;

   always #4 clk = ~clk;

   msx_memory_top #(
      .bank_bits(8)
   ) msx_memory_top_inst (
      .clk(clk),
      .reset(reset),
      .cfg_wr(cfg_wr),
      .cfg_sel(cfg_sel),
      .cfg_index(cfg_index),
      .cfg_data(cfg_data),
      .cpu_addr(cpu_addr),
      .cpu_dout(cpu_dout),
      .cpu_din(cpu_din),
      .cpu_wr(cpu_wr),
      .cpu_rd(cpu_rd),
      .cpu_mreq(cpu_mreq),
      .cpu_iorq(cpu_iorq),
      .cpu_m1(cpu_m1),
      .active_slot(active_slot),
      .ram_addr(ram_addr),
      .ram_din(ram_din),
      .ram_dout(ram_dout),
      .ram_rnw(ram_rnw),
      .ram_ce(ram_ce)
   );

   // ram model with asynchronous read
   assign ram_dout = ram_mem[ram_addr[19:0]];

   always @(posedge clk) begin
      if (ram_ce && !ram_rnw) begin
         ram_mem[ram_addr[19:0]] <= ram_din;
      end
   end

   task automatic bus_idle();
      cfg_wr      = 1'b0;
      cfg_sel     = 2'd0;
      cfg_index   = 6'd0;
      cfg_data    = '0;
      cpu_addr    = 16'h0000;
      cpu_dout    = 8'h00;
      cpu_wr      = 1'b0;
      cpu_rd      = 1'b0;
      cpu_mreq    = 1'b0;
      cpu_iorq    = 1'b0;
      cpu_m1      = 1'b0;
      active_slot = 2'd0;
   endtask

   // c config, r/w memory, i/o port
   task automatic apply_line(input logic [7:0] op, input logic [7:0] slot,
                             input logic [15:0] addr, input logic [35:0] data);
      bus_idle();
      active_slot = slot[1:0];
      cpu_addr    = addr;
      case (op)
         "c": begin
            cfg_wr    = 1'b1;
            cfg_sel   = slot[1:0];
            cfg_index = addr[5:0];
            cfg_data  = data;
         end
         "r": begin
            cpu_mreq = 1'b1;
            cpu_rd   = 1'b1;
         end
         "w": begin
            cpu_mreq = 1'b1;
            cpu_wr   = 1'b1;
            cpu_dout = data[7:0];
         end
         "i": begin
            cpu_iorq = 1'b1;
            cpu_rd   = 1'b1;
         end
         "o": begin
            cpu_iorq = 1'b1;
            cpu_wr   = 1'b1;
            cpu_dout = data[7:0];
         end
         default: begin
            $display("unknown operation in trace line %0d", line_count);
            error_count++;
         end
      endcase
   endtask

   task automatic compare(input logic [8*16-1:0] test_name, input logic [8*8-1:0] field,
                          input logic [31:0] expected, input logic [31:0] actual);
      check_count++;
      assert (expected === actual) else begin
         $display("Fail %0s %0s expected %h actual %h", test_name, field, expected, actual);
         error_count++;
      end
   endtask

   initial begin
      error_count = 0;
      check_count = 0;
      line_count  = 0;
      clk         = 1'b0;
      reset       = 1'b1;
      bus_idle();
      // fill folds every address bit into the byte
      for (int i = 0; i < 1048576; i++) begin
         ram_mem[i[19:0]] = i[7:0] ^ i[15:8] ^ {4'h0, i[19:16]};
      end
      repeat (8) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      fd = $fopen("msx_trace.txt", "r");
      if (fd == 0) begin
         $display("could not open the trace file msx_trace.txt");
         error_count++;
      end else begin
         while (!$feof(fd) && line_count < max_lines) begin
            line_count++;
            line_buf = '0;
            if ($fgets(line_buf, fd) == 0) begin
               continue;
            end
            field_count = $sscanf(line_buf, "%s %s %h %h %h %h %h %h", t_op, t_name,
                                  t_slot, t_addr, t_data, t_din, t_ram_addr, t_ce);
            // comment and blank lines
            if (field_count != 8 || t_op == "#") begin
               continue;
            end
            @(negedge clk);
            apply_line(t_op, t_slot, t_addr, t_data);
            // outputs settle long before the rising edge
            #2;
            if (t_op != "c") begin
               compare(t_name, "ram_ce", 32'(t_ce[0]), 32'(ram_ce));
            end
            if (t_op == "r" || t_op == "i") begin
               compare(t_name, "cpu_din", 32'(t_din), 32'(cpu_din));
            end
            if (t_ce[0] && t_op != "c") begin
               compare(t_name, "ram_addr", 32'(t_ram_addr), 32'(ram_addr));
            end
            // direction and write data towards the ram
            if (t_op == "r" || t_op == "w") begin
               compare(t_name, "ram_rnw", 32'(t_op == "r"), 32'(ram_rnw));
            end
            if (t_op == "w") begin
               compare(t_name, "ram_din", 32'(t_data[7:0]), 32'(ram_din));
            end
         end
         if (!$feof(fd)) begin
            $display("trace did not end within %0d lines", max_lines);
            error_count++;
         end
         $fclose(fd);
      end

      @(negedge clk);
      bus_idle();
      @(negedge clk);
      $display("%0d checks, %0d errors", check_count, error_count);
      if (error_count == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

`default_nettype wire
